// ==== project.f ====
+incdir+source
source/stream_pkg.sv
source/srl_queue.sv
source/scale_regs.sv
source/scale_operator.sv
source/stream_page.sv
tb/stream_page_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the stream page testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module stream_page_tb -f project.f -o stream_page_sim

status=0
./obj_dir/stream_page_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "simulation finished without failure"

// ==== source/scale_operator.sv ====
/* scaling operator, one output register
   data tokens get value*gain+offset, eos tokens get the segment count */

`include "stream_consts.svh"

module scale_operator
   import stream_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  token_t     i_d,      // token from input queue
   input  logic       i_v,
   output logic       i_b,      // stall toward input queue
   input  scale_cfg_t i_cfg,    // gain and offset
   output token_t     o_d,      // result register
   output logic       o_v,
   input  logic       o_b       // back-pressure from output queue
);

   logic                       take;        // input accepted this edge
   logic [`STREAM_COUNT_W-1:0] seg_count;   // data tokens since last eos
   token_t                     result;      // next value of o_d

   // busy only while a result sits stalled in the register
   assign i_b  = o_v && o_b;
   assign take = i_v && !i_b;   // empty register, or drained this cycle

   always_comb begin
      result = i_d;                                // eos flag and code pass
      if (i_d.eos) begin
         result.payload.eos.count = seg_count;     // stamp closed segment
      end else begin
         // 16-bit context, so the sum wraps mod 2^16
         result.payload.data = i_d.payload.data * i_cfg.gain + i_cfg.offset;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         o_v       <= 1'b0;
         seg_count <= '0;
      end else begin
         if (take) begin
            o_v <= 1'b1;            // new result loaded
         end else if (!o_b) begin
            o_v <= 1'b0;            // drained, nothing behind it
         end
         if (take) begin
            if (i_d.eos) begin
               seg_count <= '0;     // new segment starts
            end else begin
               seg_count <= seg_count + 1'b1;   // wraps at 4096
            end
         end
      end
   end

   // payload register, loaded only on accept
   always_ff @(posedge clock) begin
      if (take) begin
         o_d <= result;
      end
   end

   // a stalled result holds until the consumer takes it
   a_hold_stalled: assert property (@(posedge clock) disable iff (!reset)
      (o_v && o_b) |=> (o_v && $stable(o_d)))
      else $error("scale_operator: output changed under back-pressure");

endmodule

// ==== source/scale_regs.sv ====
/* operator configuration registers, gain and offset
   written by a one-cycle strobe with a one-bit address */

`include "stream_consts.svh"

module scale_regs
   import stream_pkg::*;
(
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         i_cfg_wr,     // write strobe
   input  logic                         i_cfg_addr,   // register select
   input  logic [`STREAM_PAYLOAD_W-1:0] i_cfg_data,   // write data
   output scale_cfg_t                   o_cfg         // to the operator
);

   // unity gain, so data passes unchanged after reset
   localparam logic [`STREAM_PAYLOAD_W-1:0] gain_reset =
      {{(`STREAM_PAYLOAD_W - 1){1'b0}}, 1'b1};

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         o_cfg.gain   <= gain_reset;
         o_cfg.offset <= '0;
      end else if (i_cfg_wr) begin
         case (i_cfg_addr)
            `CFG_ADDR_GAIN: begin
               o_cfg.gain <= i_cfg_data;      // multiplier
            end
            `CFG_ADDR_OFFSET: begin
               o_cfg.offset <= i_cfg_data;    // additive term
            end
            default: begin
               o_cfg <= o_cfg;                // unknown address, hold
            end
         endcase
      end
   end

   // software side must drive a clean strobe once out of reset
   a_wr_known: assert property (@(posedge clock) disable iff (!reset)
      !$isunknown(i_cfg_wr))
      else $error("scale_regs: write strobe unknown");

   // a write with an unknown address would corrupt a register
   a_addr_known: assert property (@(posedge clock) disable iff (!reset)
      i_cfg_wr |-> !$isunknown(i_cfg_addr))
      else $error("scale_regs: write address unknown");

endmodule

// ==== source/srl_queue.sv ====
/* in-page shift-register queue with valid plus back-pressure on both sides
   an up-down address picks the oldest entry under two-state empty/non-empty control */

`include "stream_consts.svh"

module srl_queue
   import stream_pkg::*;
#(
   parameter int unsigned depth = `STREAM_QUEUE_DEPTH,   // 2 to 256 entries
   parameter int unsigned width = $bits(token_t)         // word width
) (
   input  logic             clock,
   input  logic             reset,
   input  logic [width-1:0] i_d,     // input token
   input  logic             i_v,     // input valid
   output logic             i_b,     // back-pressure toward producer
   output logic [width-1:0] o_d,     // oldest token
   output logic             o_v,     // output valid
   input  logic             o_b      // back-pressure from consumer
);

   localparam int unsigned addr_w = $clog2(depth);
   localparam logic [addr_w-1:0] addr_last = addr_w'(depth - 1);   // full mark

   localparam logic st_empty    = 1'b0;   // o_v low and o_d stale
   localparam logic st_nonempty = 1'b1;   // holds addr+1 tokens

   logic              state, state_nxt;
   logic [addr_w-1:0] addr, addr_nxt;     // index of oldest entry
   logic              shift_en;           // push i_d into srl[0]
   logic              addr_full;
   logic              addr_zero;
   logic [width-1:0]  srl [depth];        // shift register storage

   assign addr_full = (addr == addr_last);
   assign addr_zero = (addr == '0);

   assign o_d = srl[addr];                          // stale when empty
   assign o_v = (state == st_nonempty);
   assign i_b = (state == st_nonempty) && addr_full; // high only when full

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= st_empty;
         addr  <= '0;
      end else begin
         state <= state_nxt;
         addr  <= addr_nxt;
      end
   end

   // storage shifts toward higher index with newest at 0
   always_ff @(posedge clock) begin
      if (shift_en) begin
         for (int i = depth - 1; i > 0; i--) begin
            srl[i] <= srl[i-1];
         end
         srl[0] <= i_d;
      end
   end

   always_comb begin
      shift_en  = 1'b0;      // idle unless a case below says otherwise
      addr_nxt  = addr;
      state_nxt = state;
      case (state)
         st_empty: begin
            if (i_v) begin                   // consume into empty queue
               shift_en  = 1'b1;
               addr_nxt  = '0;
               state_nxt = st_nonempty;
            end
         end
         st_nonempty: begin
            if (addr_full) begin             // full so no consume
               if (!o_b) begin               // produce only
                  addr_nxt = addr - 1'b1;
               end
            end else if (i_v && o_b) begin   // consume only
               shift_en = 1'b1;
               addr_nxt = addr + 1'b1;
            end else if (i_v && !o_b) begin  // consume and produce
               shift_en = 1'b1;
            end else if (!o_b) begin         // produce only and may empty
               if (addr_zero) begin
                  state_nxt = st_empty;
               end else begin
                  addr_nxt = addr - 1'b1;
               end
            end
         end
         default: begin
            state_nxt = st_empty;
         end
      endcase
   end

   // address stays inside the storage
   a_addr_range: assert property (@(posedge clock) disable iff (!reset)
      addr <= addr_last)
      else $error("srl_queue: address past depth-1");

   // a full queue keeps its newest word until it drains
   a_no_shift_full: assert property (@(posedge clock) disable iff (!reset)
      i_b |=> $stable(srl[0]))
      else $error("srl_queue: shift while full");

endmodule

// ==== source/stream_consts.svh ====
/* stream page constants
   token field widths, queue depth and configuration register addresses */

`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

`define STREAM_PAYLOAD_W   16    // payload word of a token
`define STREAM_CODE_W      4     // eos code, upper payload bits
`define STREAM_COUNT_W     12    // eos segment count, lower payload bits

`define STREAM_QUEUE_DEPTH 16    // default in-page queue depth

// configuration register map, one address bit
`define CFG_ADDR_GAIN      1'b0
`define CFG_ADDR_OFFSET    1'b1

`endif

// ==== source/stream_page.sv ====
/* stream page top, input queue -> scaling operator -> output queue
   with the gain/offset registers beside the operator */

`include "stream_consts.svh"

module stream_page
   import stream_pkg::*;
(
   input  logic                         clock,
   input  logic                         reset,
   input  token_t                       i_d,          // page input stream
   input  logic                         i_v,
   output logic                         i_b,
   output token_t                       o_d,          // page output stream
   output logic                         o_v,
   input  logic                         o_b,
   input  logic                         i_cfg_wr,     // config write strobe
   input  logic                         i_cfg_addr,
   input  logic [`STREAM_PAYLOAD_W-1:0] i_cfg_data
);

   token_t     in_d;      // in_queue -> operator
   logic       in_v;
   logic       in_b;
   token_t     op_d;      // operator -> out_queue
   logic       op_v;
   logic       op_b;
   scale_cfg_t cfg;       // registers -> operator

   srl_queue #(
      .depth (`STREAM_QUEUE_DEPTH),
      .width ($bits(token_t))
   ) in_queue (
      .clock (clock),
      .reset (reset),
      .i_d   (i_d),
      .i_v   (i_v),
      .i_b   (i_b),
      .o_d   (in_d),
      .o_v   (in_v),
      .o_b   (in_b)
   );

   scale_regs regs (
      .clock      (clock),
      .reset      (reset),
      .i_cfg_wr   (i_cfg_wr),
      .i_cfg_addr (i_cfg_addr),
      .i_cfg_data (i_cfg_data),
      .o_cfg      (cfg)
   );

   scale_operator op (
      .clock (clock),
      .reset (reset),
      .i_d   (in_d),
      .i_v   (in_v),
      .i_b   (in_b),
      .i_cfg (cfg),
      .o_d   (op_d),
      .o_v   (op_v),
      .o_b   (op_b)
   );

   srl_queue #(
      .depth (`STREAM_QUEUE_DEPTH),
      .width ($bits(token_t))
   ) out_queue (
      .clock (clock),
      .reset (reset),
      .i_d   (op_d),
      .i_v   (op_v),
      .i_b   (op_b),
      .o_d   (o_d),
      .o_v   (o_v),
      .o_b   (o_b)
   );

endmodule

// ==== source/stream_pkg.sv ====
/* stream page types
   token word with eos flag and a payload read as data or as eos fields */

`include "stream_consts.svh"

package stream_pkg;

   // eos view of the payload, code on top
   typedef struct packed {
      logic [`STREAM_CODE_W-1:0]  code;    // end-of-stream code, passed through
      logic [`STREAM_COUNT_W-1:0] count;   // data tokens in the closed segment
   } eos_fields_t;

   // one payload word, decoded by the eos flag
   typedef union packed {
      logic [`STREAM_PAYLOAD_W-1:0] data;  // data token value
      eos_fields_t                  eos;   // eos token fields
   } payload_u;

   // queue word and page port type, eos flag concatenated on top
   typedef struct packed {
      logic     eos;                       // 1 = end-of-stream token
      payload_u payload;
   } token_t;

   // operator configuration
   typedef struct packed {
      logic [`STREAM_PAYLOAD_W-1:0] gain;     // multiplier
      logic [`STREAM_PAYLOAD_W-1:0] offset;   // added after the multiply
   } scale_cfg_t;

endpackage

// ==== tb/stream_page_tb.sv ====
/* stream page testbench, random tokens through queue, operator and queue
   reference model queue, concurrent checks, watchdog and verdict */

`include "stream_consts.svh"

module stream_page_tb
   import stream_pkg::*;
;

   localparam int full_cap   = 2 * `STREAM_QUEUE_DEPTH + 1;   // both queues + op register
   localparam int watchdog_t = 400 * 12 * 40;                 // tokens x cycles x period

   logic                         clock;
   logic                         reset;
   token_t                       i_d;
   logic                         i_v;
   logic                         i_b;
   token_t                       o_d;
   logic                         o_v;
   logic                         o_b;
   logic                         i_cfg_wr;
   logic                         i_cfg_addr;
   logic [`STREAM_PAYLOAD_W-1:0] i_cfg_data;

   integer                       seed = 32'hdae9;
   int                           bp_mode;            // 0 off, 1 random, 2 long stalls
   logic                         idle_chk;           // no traffic expected
   logic [`STREAM_PAYLOAD_W-1:0] cfg_gain;           // shadow of the registers
   logic [`STREAM_PAYLOAD_W-1:0] cfg_offset;
   logic [`STREAM_COUNT_W-1:0]   model_seg = '0;     // data tokens since last eos
   token_t                       exp_q[$];           // expected page output
   token_t                       exp_head;
   logic                         exp_have = 1'b0;
   int                           in_flight = 0;      // accepted, not yet delivered
   int                           full_seen = 0;
   int                           tokens_out = 0;
   int                           err_value = 0;
   int                           err_other = 0;

   stream_page dut (
      .clock      (clock),
      .reset      (reset),
      .i_d        (i_d),
      .i_v        (i_v),
      .i_b        (i_b),
      .o_d        (o_d),
      .o_v        (o_v),
      .o_b        (o_b),
      .i_cfg_wr   (i_cfg_wr),
      .i_cfg_addr (i_cfg_addr),
      .i_cfg_data (i_cfg_data)
   );

   initial begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   // output back-pressure pattern, driven on the falling edge
   initial begin
      int stall_cnt;
      stall_cnt = 0;
      o_b = 1'b0;
      forever begin
         @(negedge clock);
         case (bp_mode)
            1: o_b = (($random(seed) & 3) == 0);   // short random stalls
            2: begin
               stall_cnt = (stall_cnt + 1) % 100;
               o_b = (stall_cnt < 70);              // 70 high, 30 low
            end
            default: o_b = 1'b0;
         endcase
      end
   end

   // wide multiply then keep the low 16 bits
   function automatic logic [`STREAM_PAYLOAD_W-1:0] scale_value(
      input logic [`STREAM_PAYLOAD_W-1:0] value,
      input logic [`STREAM_PAYLOAD_W-1:0] gain,
      input logic [`STREAM_PAYLOAD_W-1:0] offset);
      logic [31:0] wide;
      wide = 32'(value) * 32'(gain) + 32'(offset);
      return wide[`STREAM_PAYLOAD_W-1:0];
   endfunction

   // reference model, updated on every transfer edge
   always @(posedge clock) begin
      token_t exp_tok;
      if (reset) begin
         if (i_v && !i_b) begin                      // input accepted
            exp_tok = i_d;
            if (i_d.eos) begin
               exp_tok.payload.eos.count = model_seg;
               model_seg = '0;
            end else begin
               exp_tok.payload.data = scale_value(i_d.payload.data, cfg_gain, cfg_offset);
               model_seg = model_seg + 12'd1;        // wraps at 4096
            end
            exp_q.push_back(exp_tok);
         end
         if (o_v && !o_b && exp_q.size() != 0) begin  // output delivered
            void'(exp_q.pop_front());
            tokens_out++;
         end
         if (in_flight == full_cap && i_b) begin
            full_seen++;
         end
         exp_have  <= (exp_q.size() != 0);
         in_flight <= exp_q.size();
         if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
         end
      end
   end

   a_out_value: assert property (@(posedge clock) disable iff (!reset)
      (o_v && !o_b && exp_have) |-> (o_d == exp_head))
      else begin
         err_value++;
         $display("ERR %0t: output token %h, expected %h", $time,
                  $sampled(o_d), $sampled(exp_head));
      end

   a_no_extra: assert property (@(posedge clock) disable iff (!reset)
      o_v |-> exp_have)
      else begin
         err_other++;
         $display("output valid at %0t with no token outstanding", $time);
      end

   a_out_hold: assert property (@(posedge clock) disable iff (!reset)
      (o_v && o_b) |=> (o_v && $stable(o_d)))
      else begin
         err_value++;
         $display("ERR %0t: output changed under back-pressure, now %h", $time,
                  $sampled(o_d));
      end

   a_idle_quiet: assert property (@(posedge clock) disable iff (!reset)
      idle_chk |-> (!o_v && !i_b))
      else begin
         err_value++;
         $display("ERR %0t: idle page shows o_v %b i_b %b", $time,
                  $sampled(o_v), $sampled(i_b));
      end

   a_full_bp: assert property (@(posedge clock) disable iff (!reset)
      (in_flight == full_cap) |-> i_b)
      else begin
         err_value++;
         $display("ERR %0t: page full but input back-pressure low", $time);
      end

   a_capacity: assert property (@(posedge clock) disable iff (!reset)
      in_flight <= full_cap)
      else begin
         err_other++;
         $display("page accepted more tokens than it can hold at %0t", $time);
      end

   // hold token until back-pressure seen low at the falling edge
   task automatic send_token(input token_t tok);
      while (($random(seed) & 3) == 0) begin     // random valid gap
         i_v = 1'b0;
         @(negedge clock);
      end
      i_d = tok;
      i_v = 1'b1;
      while (i_b) begin                          // i_b settled since last rise
         @(negedge clock);
      end
      @(negedge clock);
      i_v = 1'b0;
   endtask

   // random data with random eos spacing, closing eos at the end
   task automatic send_burst(input int count);
      token_t tok;
      for (int n = 0; n < count; n++) begin
         tok = '0;
         if (n == count - 1 || ($random(seed) & 7) == 0) begin
            tok.eos = 1'b1;
            tok.payload.eos.code  = 4'($random(seed));
            tok.payload.eos.count = 12'($random(seed));   // replaced by the page
         end else begin
            tok.payload.data = 16'($random(seed));
         end
         send_token(tok);
      end
   endtask

   task automatic drain();
      while (in_flight != 0) begin
         @(negedge clock);
      end
      repeat (4) @(negedge clock);
   endtask

   task automatic write_cfg(input logic addr, input logic [`STREAM_PAYLOAD_W-1:0] data);
      i_cfg_wr   = 1'b1;
      i_cfg_addr = addr;
      i_cfg_data = data;
      @(negedge clock);
      i_cfg_wr = 1'b0;
      if (addr == `CFG_ADDR_GAIN) begin
         cfg_gain = data;
      end else begin
         cfg_offset = data;
      end
   endtask

   initial begin
      #(watchdog_t);
      $display("watchdog expired, the run did not finish in time");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      reset      = 1'b0;
      i_d        = '0;
      i_v        = 1'b0;
      i_cfg_wr   = 1'b0;
      i_cfg_addr = 1'b0;
      i_cfg_data = '0;
      idle_chk   = 1'b0;
      bp_mode    = 0;
      cfg_gain   = 16'd1;                  // register reset values
      cfg_offset = 16'd0;
      repeat (4) @(negedge clock);
      reset    = 1'b1;
      idle_chk = 1'b1;                     // quiet page after reset
      repeat (12) @(negedge clock);
      idle_chk = 1'b0;

      bp_mode = 1;                         // unity gain pass-through
      send_burst(60);
      drain();

      bp_mode = 0;                         // reconfigure while idle
      write_cfg(`CFG_ADDR_GAIN, 16'($random(seed)));
      write_cfg(`CFG_ADDR_OFFSET, 16'($random(seed)));
      bp_mode = 1;
      send_burst(120);
      drain();

      bp_mode = 2;                         // long stalls fill the page
      send_burst(150);
      bp_mode = 0;
      drain();

      if (exp_q.size() != 0) begin
         err_other++;
         $display("%0d expected tokens never came out", exp_q.size());
      end
      if (full_seen == 0) begin
         err_other++;
         $display("page never filled up under output back-pressure");
      end
      $display("closing: %0d tokens out, %0d value errors, %0d other errors",
               tokens_out, err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
